//--- compile.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_inst_decoder.sv
rtl/dma_req_fifo.sv
rtl/dma_nd_midend.sv
rtl/dma_rsp_spill.sv
rtl/dma_frontend_top.sv
test/dma_checker.sv
test/tb_dma_frontend.sv

//--- Makefile
# Verilator build for the DMA frontend testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_frontend
RTL_TOP   ?= dma_frontend_top
FLIST     ?= compile.f
BUILD     ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(BUILD)

//--- test/tb_dma_frontend.sv
// --------------------------------------------------
// DMA frontend testbench
// instruction table, burst backend model and timeout
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "dma_macros.svh"

module tb_dma_frontend;

    typedef struct {
        logic [31:0] op;
        logic [31:0] arga;
        logic [31:0] argb;
        bit          rsp;
        bit          wait_idle;
        bit          hold;
        bit          stall;
    } entry_t;

    logic                clk = 1'b0;
    logic                rst_n;
    dma_pkg::acc_req_t   acc_req;
    logic                acc_req_valid, acc_req_ready;
    dma_pkg::acc_rsp_t   acc_rsp;
    logic                acc_rsp_valid, acc_rsp_ready;
    dma_pkg::burst_req_t burst_req;
    logic                burst_valid, burst_ready, burst_done, busy;
    logic                chk_idle;
    int                  chk_errors, chk_rsp_cnt;

    entry_t tbl[$];
    integer seed = 37552;
    int     cycle = 0;
    int     limit = 0;
    int     last_due = 0;
    int     done_due[$];
    int     stim_errors = 0;
    int     exp_rsp_cnt = 0;
    logic   hold = 1'b0;
    logic   burst_taken = 1'b0;

    dma_frontend_top DUT (
        .clk_i (clk), .rst_n_i (rst_n),
        .acc_req_i (acc_req), .acc_req_valid_i (acc_req_valid),
        .acc_req_ready_o (acc_req_ready),
        .acc_rsp_o (acc_rsp), .acc_rsp_valid_o (acc_rsp_valid),
        .acc_rsp_ready_i (acc_rsp_ready),
        .burst_req_o (burst_req), .burst_valid_o (burst_valid),
        .burst_ready_i (burst_ready), .burst_done_i (burst_done), .busy_o (busy)
    );

    dma_checker i_checker (
        .clk_i (clk), .rst_n_i (rst_n),
        .req_i (acc_req), .req_valid_i (acc_req_valid), .req_ready_i (acc_req_ready),
        .rsp_i (acc_rsp), .rsp_valid_i (acc_rsp_valid), .rsp_ready_i (acc_rsp_ready),
        .burst_i (burst_req), .burst_valid_i (burst_valid), .burst_ready_i (burst_ready),
        .burst_done_i (burst_done), .busy_i (busy),
        .idle_o (chk_idle), .err_cnt_o (chk_errors), .rsp_cnt_o (chk_rsp_cnt)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] op_word(input logic [6:0] funct, input logic [1:0] cfg);
        return {funct, 3'b000, cfg, 20'h0};
    endfunction

    task automatic add_entry(input logic [31:0] op, input logic [31:0] arga,
                             input logic [31:0] argb, input bit rsp, input bit wait_idle,
                             input bit hold_be, input bit stall);
        entry_t e;
        e.op        = op;
        e.arga      = arga;
        e.argb      = argb;
        e.rsp       = rsp;
        e.wait_idle = wait_idle;
        e.hold      = hold_be;
        e.stall     = stall;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // 1D copy
        add_entry(op_word(`DMA_OP_DMSRC, 2'd0), 32'h1000, 32'h0, 0, 0, 0, 0);
        add_entry(op_word(`DMA_OP_DMDST, 2'd0), 32'h2000, 32'h0, 0, 0, 0, 0);
        add_entry(op_word(`DMA_OP_DMCPY, 2'd0), 32'h40, 32'h0, 1, 0, 0, 0);
        // 2D copy and its 1D twin
        add_entry(op_word(`DMA_OP_DMSTR, 2'd0), 32'h100, 32'h200, 0, 0, 0, 0);
        add_entry(op_word(`DMA_OP_DMREP, 2'd0), 32'd3, 32'h0, 0, 0, 0, 0);
        add_entry(op_word(`DMA_OP_DMCPY, 2'd0), 32'h20, 32'h2, 1, 0, 0, 0);
        add_entry(op_word(`DMA_OP_DMCPY, 2'd0), 32'h20, 32'h0, 1, 0, 0, 0);
        // immediate and register forms
        add_entry(op_word(`DMA_OP_DMCPYI, 2'd2), 32'h10, 32'h0, 1, 0, 0, 0);
        add_entry(op_word(`DMA_OP_DMCPY, 2'd0), 32'h10, 32'h2, 1, 0, 0, 0);
        add_entry(op_word(`DMA_OP_DMSTATI, 2'd1), 32'h0, 32'h0, 1, 1, 0, 0);
        add_entry(op_word(`DMA_OP_DMSTAT, 2'd0), 32'h0, 32'h1, 1, 1, 0, 0);
        add_entry(op_word(`DMA_OP_DMSTAT, 2'd0), 32'h0, 32'h0, 1, 1, 0, 0);
        add_entry(op_word(`DMA_OP_DMSTATI, 2'd2), 32'h0, 32'h0, 1, 1, 0, 0);
        // backend stalled, busy and then a full queue
        add_entry(op_word(`DMA_OP_DMCPYI, 2'd2), 32'h8, 32'h0, 1, 0, 1, 0);
        add_entry(op_word(`DMA_OP_DMSTATI, 2'd2), 32'h0, 32'h0, 1, 0, 1, 0);
        add_entry(op_word(`DMA_OP_DMSTAT, 2'd0), 32'h0, 32'h1, 1, 0, 1, 0);
        add_entry(op_word(`DMA_OP_DMCPY, 2'd0), 32'h8, 32'h0, 1, 0, 1, 0);
        add_entry(op_word(`DMA_OP_DMCPY, 2'd0), 32'h8, 32'h2, 1, 0, 1, 0);
        add_entry(op_word(`DMA_OP_DMCPY, 2'd0), 32'h8, 32'h0, 1, 0, 1, 0);
        add_entry(op_word(`DMA_OP_DMSTATI, 2'd3), 32'h0, 32'h0, 1, 0, 1, 0);
        add_entry(op_word(`DMA_OP_DMCPY, 2'd0), 32'h4, 32'h0, 1, 0, 1, 1);
        add_entry(op_word(`DMA_OP_DMSTAT, 2'd0), 32'h0, 32'h3, 1, 1, 0, 0);
        add_entry(op_word(`DMA_OP_DMSTAT, 2'd0), 32'h0, 32'h0, 1, 1, 0, 0);
        // zero reps, then unknown ops
        add_entry(op_word(`DMA_OP_DMREP, 2'd0), 32'd0, 32'h0, 0, 0, 0, 0);
        add_entry(op_word(`DMA_OP_DMCPYI, 2'd2), 32'h30, 32'h0, 1, 0, 0, 0);
        add_entry(op_word(7'd9, 2'd0), 32'h0, 32'h0, 1, 0, 0, 0);
        add_entry(op_word(7'h7f, 2'd3), 32'h5, 32'h6, 1, 0, 0, 0);
    endtask

    task automatic wait_quiet();
        @(posedge clk);
        while (!chk_idle) @(posedge clk);
        // retire and ID update trail the last done pulse
        repeat (4) @(posedge clk);
    endtask

    //--------------------------------------------------
    // backend model, done pulses in issue order
    //--------------------------------------------------
    // burst handshake taken mid-cycle while the bus is stable
    always @(negedge clk) begin
        burst_taken = burst_valid && burst_ready;
    end

    always @(posedge clk) begin : backend
        int due;
        cycle = cycle + 1;
        if (burst_taken) begin
            due = cycle + 1 + ($random(seed) & 3);
            if (due <= last_due) due = last_due + 1;
            last_due = due;
            done_due.push_back(due);
        end
        #5;
        burst_done = (done_due.size() != 0) && (done_due[0] == cycle);
        if (burst_done) void'(done_due.pop_front());
        burst_ready   = !hold && (($random(seed) & 3) != 0);
        acc_rsp_ready = (($random(seed) & 3) != 0);
    end

    initial begin : timeout
        wait (limit != 0);
        while (cycle < limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        entry_t e;
        int     waited;
        acc_req       = '0;
        acc_req_valid = 1'b0;
        acc_rsp_ready = 1'b0;
        burst_ready   = 1'b0;
        burst_done    = 1'b0;
        rst_n         = 1'b0;
        build_table();
        limit = tbl.size() * 40;
        repeat (16) @(posedge clk);
        #5 rst_n = 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            if (e.wait_idle) wait_quiet();
            @(posedge clk);
            hold = e.hold;
            #5;
            acc_req.tag      = 5'(i);
            acc_req.op.raw   = e.op;
            acc_req.arga     = e.arga;
            acc_req.argb     = e.argb;
            acc_req_valid    = 1'b1;
            if (e.rsp) exp_rsp_cnt++;
            waited = 0;
            @(negedge clk);
            while (!acc_req_ready) begin
                waited++;
                // let the stalled backend drain the queue
                if (e.stall && waited == 8) hold = 1'b0;
                @(negedge clk);
            end
            if (e.stall && waited < 8) begin
                stim_errors++;
                $display("copy %0d was accepted while the job queue was full", i);
            end
            @(posedge clk);
            #5 acc_req_valid = 1'b0;
        end
        wait_quiet();
        if (chk_rsp_cnt != exp_rsp_cnt) begin
            stim_errors++;
            $display("expected %0d responses but %0d arrived", exp_rsp_cnt, chk_rsp_cnt);
        end
        $display("errors: checker %0d, stimulus %0d", chk_errors, stim_errors);
        if (chk_errors == 0 && stim_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/dma_checker.sv
// --------------------------------------------------
// DMA frontend checker
// models the decoder state and compares responses
// and bursts seen at the DUT ports
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "dma_macros.svh"

module dma_checker (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire dma_pkg::acc_req_t   req_i,
    input  wire logic                req_valid_i,
    input  wire logic                req_ready_i,
    input  wire dma_pkg::acc_rsp_t   rsp_i,
    input  wire logic                rsp_valid_i,
    input  wire logic                rsp_ready_i,
    input  wire dma_pkg::burst_req_t burst_i,
    input  wire logic                burst_valid_i,
    input  wire logic                burst_ready_i,
    input  wire logic                burst_done_i,
    input  wire logic                busy_i,
    output logic                     idle_o,
    output int                       err_cnt_o,
    output int                       rsp_cnt_o
);

    // reference copy of the configuration and ID state
    logic [31:0] src, dst, src_stride, dst_stride, reps, next_id;
    int          issued, done_jobs, errors, rsp_cnt;
    // bursts handed to the backend and not done, samples with no job in flight
    int          out_bursts, quiet;

    dma_pkg::acc_rsp_t   exp_rsp[$];
    dma_pkg::burst_req_t exp_burst[$];
    // bursts still outstanding per job, oldest first
    int                  job_left[$];
    dma_pkg::acc_rsp_t   er;
    dma_pkg::burst_req_t eb;

    task automatic mismatch(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic problem(input string msg);
        errors++;
        $display("checker at %0t: %s", $time, msg);
    endtask

    task automatic accept(input dma_pkg::acc_req_t req);
        logic [6:0]          funct;
        logic [1:0]          sel;
        logic [31:0]         n;
        dma_pkg::acc_rsp_t   r;
        dma_pkg::burst_req_t b;
        funct = req.op.raw[31:25];
        sel = (funct == `DMA_OP_DMCPYI || funct == `DMA_OP_DMSTATI) ?
              req.op.raw[21:20] : req.argb[1:0];
        r.tag   = req.tag;
        r.data  = '0;
        r.error = 1'b0;
        case (funct)
            `DMA_OP_DMSRC: src = req.arga;
            `DMA_OP_DMDST: dst = req.arga;
            `DMA_OP_DMSTR: begin
                src_stride = req.arga;
                dst_stride = req.argb;
            end
            `DMA_OP_DMREP: reps = req.arga;
            `DMA_OP_DMCPYI, `DMA_OP_DMCPY: begin
                // 2D copies run reps bursts, zero counting as one
                n = sel[1] ? ((reps == '0) ? 32'd1 : reps) : 32'd1;
                for (int k = 0; k < int'(n); k++) begin
                    b.src    = src + 32'(k) * src_stride;
                    b.dst    = dst + 32'(k) * dst_stride;
                    b.length = req.arga;
                    exp_burst.push_back(b);
                end
                job_left.push_back(int'(n));
                issued++;
                r.data  = next_id;
                next_id = next_id + 32'd1;
                exp_rsp.push_back(r);
            end
            `DMA_OP_DMSTATI, `DMA_OP_DMSTAT: begin
                case (sel)
                    `DMA_STAT_COMPLETED: r.data = 32'(done_jobs);
                    `DMA_STAT_NEXT:      r.data = next_id;
                    `DMA_STAT_BUSY:      r.data = {31'b0, issued != done_jobs};
                    default: r.data = {31'b0, (issued - done_jobs) > `DMA_FIFO_DEPTH};
                endcase
                exp_rsp.push_back(r);
            end
            default: begin
                r.error = 1'b1;
                exp_rsp.push_back(r);
            end
        endcase
    endtask

    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            if (req_ready_i || rsp_valid_i || burst_valid_i || busy_i) begin
                mismatch("output high during reset");
            end
            src        = '0;
            dst        = '0;
            src_stride = '0;
            dst_stride = '0;
            reps       = '0;
            next_id    = 32'd1;
            issued     = 0;
            done_jobs  = 0;
            out_bursts = 0;
            quiet      = 0;
        end else begin
            // a burst out at the backend keeps the midend busy
            if (out_bursts > 0 && !busy_i) begin
                mismatch("busy low while a burst is outstanding");
            end
            // busy drops two cycles after the last done pulse
            if (quiet >= 2 && busy_i) begin
                mismatch("busy high with no job in flight");
            end
            if (burst_done_i) begin
                if (job_left.size() == 0) begin
                    problem("done pulse while no burst was outstanding");
                end else begin
                    out_bursts--;
                    job_left[0] = job_left[0] - 1;
                    if (job_left[0] == 0) begin
                        void'(job_left.pop_front());
                        done_jobs++;
                    end
                end
            end
            if (req_valid_i && req_ready_i) begin
                accept(req_i);
            end
            if (rsp_valid_i && rsp_ready_i) begin
                rsp_cnt++;
                if (exp_rsp.size() == 0) begin
                    problem("response arrived with none expected");
                end else begin
                    er = exp_rsp.pop_front();
                    if (rsp_i !== er) begin
                        mismatch($sformatf(
                            "rsp tag %0d data %0h err %0b, exp tag %0d data %0h err %0b",
                            rsp_i.tag, rsp_i.data, rsp_i.error, er.tag, er.data, er.error));
                    end
                end
            end
            if (burst_valid_i && burst_ready_i) begin
                out_bursts++;
                if (exp_burst.size() == 0) begin
                    problem("burst issued with none expected");
                end else begin
                    eb = exp_burst.pop_front();
                    if (burst_i !== eb) begin
                        mismatch($sformatf("burst %0h->%0h len %0h, exp %0h->%0h len %0h",
                            burst_i.src, burst_i.dst, burst_i.length,
                            eb.src, eb.dst, eb.length));
                    end
                end
            end
            quiet = (job_left.size() == 0) ? quiet + 1 : 0;
        end
        idle_o    <= (exp_rsp.size() == 0) && (exp_burst.size() == 0) && (job_left.size() == 0);
        err_cnt_o <= errors;
        rsp_cnt_o <= rsp_cnt;
    end

endmodule

`default_nettype wire

//--- rtl/dma_frontend_top.sv
// --------------------------------------------------
// DMA instruction frontend
// decoder, job queue, 2D midend and response
// spill register
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module dma_frontend_top (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    // accelerator bus
    input  wire dma_pkg::acc_req_t acc_req_i,
    input  wire logic              acc_req_valid_i,
    output logic                   acc_req_ready_o,
    output dma_pkg::acc_rsp_t      acc_rsp_o,
    output logic                   acc_rsp_valid_o,
    input  wire logic              acc_rsp_ready_i,
    // backend
    output dma_pkg::burst_req_t    burst_req_o,
    output logic                   burst_valid_o,
    input  wire logic              burst_ready_i,
    input  wire logic              burst_done_i,
    output logic                   busy_o
);

    dma_pkg::nd_job_t  dec_job, fifo_job;
    logic              dec_job_valid, dec_job_ready;
    logic              fifo_job_valid, fifo_job_ready, fifo_empty;
    dma_pkg::acc_rsp_t dec_rsp;
    logic              dec_rsp_valid, dec_rsp_ready;
    logic              mid_retire, mid_busy, job_busy;

    // queued jobs count as busy too
    assign job_busy = mid_busy | ~fifo_empty;
    assign busy_o   = mid_busy;

    dma_inst_decoder i_decoder (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .acc_req_i       (acc_req_i),
        .acc_req_valid_i (acc_req_valid_i),
        .acc_req_ready_o (acc_req_ready_o),
        .job_o           (dec_job),
        .job_valid_o     (dec_job_valid),
        .job_ready_i     (dec_job_ready),
        .rsp_o           (dec_rsp),
        .rsp_valid_o     (dec_rsp_valid),
        .rsp_ready_i     (dec_rsp_ready),
        .job_retire_i    (mid_retire),
        .job_busy_i      (job_busy)
    );

    dma_req_fifo i_req_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .job_i       (dec_job),
        .job_valid_i (dec_job_valid),
        .job_ready_o (dec_job_ready),
        .job_o       (fifo_job),
        .job_valid_o (fifo_job_valid),
        .job_ready_i (fifo_job_ready),
        .empty_o     (fifo_empty)
    );

    dma_nd_midend i_midend (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .job_i         (fifo_job),
        .job_valid_i   (fifo_job_valid),
        .job_ready_o   (fifo_job_ready),
        .burst_req_o   (burst_req_o),
        .burst_valid_o (burst_valid_o),
        .burst_ready_i (burst_ready_i),
        .burst_done_i  (burst_done_i),
        .job_retire_o  (mid_retire),
        .job_busy_o    (mid_busy)
    );

    dma_rsp_spill i_rsp_spill (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .rsp_i           (dec_rsp),
        .rsp_valid_i     (dec_rsp_valid),
        .rsp_ready_o     (dec_rsp_ready),
        .acc_rsp_o       (acc_rsp_o),
        .acc_rsp_valid_o (acc_rsp_valid_o),
        .acc_rsp_ready_i (acc_rsp_ready_i)
    );

endmodule

`default_nettype wire

//--- rtl/dma_rsp_spill.sv
// --------------------------------------------------
// DMA response spill register
// two-entry buffer that cuts the ready path
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module dma_rsp_spill (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire dma_pkg::acc_rsp_t rsp_i,
    input  wire logic              rsp_valid_i,
    output logic                   rsp_ready_o,
    output dma_pkg::acc_rsp_t      acc_rsp_o,
    output logic                   acc_rsp_valid_o,
    input  wire logic              acc_rsp_ready_i
);

    // slot a drives the output, slot b catches overflow
    dma_pkg::acc_rsp_t a_q, b_q;
    logic              a_full_q, b_full_q;
    logic              push, pop;

    assign rsp_ready_o     = ~b_full_q;
    assign acc_rsp_valid_o = a_full_q;
    assign acc_rsp_o       = a_q;

    assign push = rsp_valid_i & rsp_ready_o;
    assign pop  = a_full_q & acc_rsp_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else if (pop) begin
            if (b_full_q) begin
                b_full_q <= 1'b0;
            end else begin
                a_full_q <= push;
            end
        end else if (push) begin
            if (a_full_q) begin
                b_full_q <= 1'b1;
            end else begin
                a_full_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop && b_full_q) begin
            a_q <= b_q;
        end else if (push && (pop || !a_full_q)) begin
            a_q <= rsp_i;
        end else if (push) begin
            b_q <= rsp_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/dma_nd_midend.sv
// --------------------------------------------------
// DMA 2D midend
// splits a job into strided 1D bursts and retires it
// once every burst has completed
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "dma_macros.svh"

module dma_nd_midend (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire dma_pkg::nd_job_t job_i,
    input  wire logic             job_valid_i,
    output logic                  job_ready_o,
    output dma_pkg::burst_req_t   burst_req_o,
    output logic                  burst_valid_o,
    input  wire logic             burst_ready_i,
    input  wire logic             burst_done_i,
    output logic                  job_retire_o,
    output logic                  job_busy_o
);

    localparam int unsigned AW = `DMA_ADDR_W;

    logic          busy_q, retire_q;
    // bursts still to issue, bursts issued but not done
    logic [AW-1:0] left_q, pend_q;
    logic [AW-1:0] src_q, dst_q, len_q, src_stride_q, dst_stride_q;

    logic load, burst_fire, done, last_done;

    assign job_ready_o   = ~busy_q;
    assign load          = job_valid_i & job_ready_o;
    assign burst_valid_o = busy_q & (left_q != '0);
    assign burst_fire    = burst_valid_o & burst_ready_i;
    assign done          = burst_done_i & busy_q;
    assign last_done     = done & ~retire_q & (left_q == '0) & (pend_q == AW'(1));

    assign burst_req_o.src    = src_q;
    assign burst_req_o.dst    = dst_q;
    assign burst_req_o.length = len_q;

    assign job_retire_o = retire_q;
    assign job_busy_o   = busy_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            retire_q <= 1'b0;
            left_q   <= '0;
            pend_q   <= '0;
        end else begin
            retire_q <= last_done;
            if (load) begin
                busy_q <= 1'b1;
                // zero reps still means one burst
                left_q <= (!job_i.twod || job_i.reps == '0) ? AW'(1) : job_i.reps;
            end else begin
                if (retire_q) begin
                    busy_q <= 1'b0;
                end
                if (burst_fire) begin
                    left_q <= left_q - 1'b1;
                end
            end
            case ({burst_fire, done})
                2'b10:   pend_q <= pend_q + 1'b1;
                2'b01:   pend_q <= pend_q - 1'b1;
                default: ;
            endcase
        end
    end

    // address generation
    always_ff @(posedge clk_i) begin
        if (load) begin
            src_q        <= job_i.src;
            dst_q        <= job_i.dst;
            len_q        <= job_i.length;
            src_stride_q <= job_i.src_stride;
            dst_stride_q <= job_i.dst_stride;
        end else if (burst_fire) begin
            src_q <= src_q + src_stride_q;
            dst_q <= dst_q + dst_stride_q;
        end
    end

endmodule

`default_nettype wire

//--- rtl/dma_req_fifo.sv
// --------------------------------------------------
// DMA job queue
// circular buffer between decoder and midend
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "dma_macros.svh"

module dma_req_fifo (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire dma_pkg::nd_job_t job_i,
    input  wire logic             job_valid_i,
    output logic                  job_ready_o,
    output dma_pkg::nd_job_t      job_o,
    output logic                  job_valid_o,
    input  wire logic             job_ready_i,
    output logic                  empty_o
);

    localparam int unsigned DEPTH = `DMA_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    dma_pkg::nd_job_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push, pop;

    assign job_ready_o = (count_q != CNT_W'(DEPTH));
    assign job_valid_o = (count_q != '0);
    assign empty_o     = (count_q == '0);
    assign job_o       = mem[rd_ptr_q];

    assign push = job_valid_i & job_ready_o;
    assign pop  = job_valid_o & job_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= job_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/dma_inst_decoder.sv
// --------------------------------------------------
// DMA instruction decoder
// holds the job configuration and transfer IDs,
// launches copies and answers status requests
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "dma_macros.svh"

module dma_inst_decoder (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire dma_pkg::acc_req_t acc_req_i,
    input  wire logic              acc_req_valid_i,
    output logic                   acc_req_ready_o,
    output dma_pkg::nd_job_t       job_o,
    output logic                   job_valid_o,
    input  wire logic              job_ready_i,
    output dma_pkg::acc_rsp_t      rsp_o,
    output logic                   rsp_valid_o,
    input  wire logic              rsp_ready_i,
    input  wire logic              job_retire_i,
    input  wire logic              job_busy_i
);

    localparam int unsigned DW = `DMA_DATA_W;
    localparam int unsigned AW = `DMA_ADDR_W;

    // configuration registers
    logic [AW-1:0] src_q, dst_q, src_stride_q, dst_stride_q, reps_q;
    // transfer ID counters
    logic [DW-1:0] next_id_q, completed_id_q;

    logic [`DMA_OP_FUNCT_W-1:0] funct;
    logic [`DMA_OP_CFG_W-1:0]   sel_bits;
    logic                       twod;
    logic                       req_fire;

    assign funct = acc_req_i.op.fields.funct;

    // immediate variants carry config/status in the op word, others in argb
    assign sel_bits = (funct == `DMA_OP_DMCPYI || funct == `DMA_OP_DMSTATI) ?
                      acc_req_i.op.fields.cfg : acc_req_i.argb[`DMA_OP_CFG_W-1:0];
    assign twod     = sel_bits[`DMA_CFG_TWOD_BIT];
    assign req_fire = acc_req_valid_i & acc_req_ready_o;

    always_comb begin
        job_o.src        = src_q;
        job_o.dst        = dst_q;
        job_o.length     = acc_req_i.arga;
        job_o.src_stride = src_stride_q;
        job_o.dst_stride = dst_stride_q;
        // 1D copies always run a single burst
        job_o.reps       = twod ? reps_q : AW'(1);
        job_o.twod       = twod;
    end

    //--------------------------------------------------
    // decode and handshake
    //--------------------------------------------------
    always_comb begin
        acc_req_ready_o = 1'b0;
        job_valid_o     = 1'b0;
        rsp_valid_o     = 1'b0;
        rsp_o           = '0;
        rsp_o.tag       = acc_req_i.tag;

        if (acc_req_valid_i) begin
            case (funct)
                `DMA_OP_DMSRC, `DMA_OP_DMDST, `DMA_OP_DMSTR, `DMA_OP_DMREP: begin
                    acc_req_ready_o = 1'b1;
                end
                `DMA_OP_DMCPYI, `DMA_OP_DMCPY: begin
                    // hold the job back until a response slot is free
                    job_valid_o = rsp_ready_i;
                    rsp_o.data  = next_id_q;
                    if (rsp_ready_i && job_ready_i) begin
                        acc_req_ready_o = 1'b1;
                        rsp_valid_o     = 1'b1;
                    end
                end
                `DMA_OP_DMSTATI, `DMA_OP_DMSTAT: begin
                    case (sel_bits)
                        `DMA_STAT_COMPLETED: rsp_o.data = completed_id_q;
                        `DMA_STAT_NEXT:      rsp_o.data = next_id_q;
                        `DMA_STAT_BUSY:      rsp_o.data = {{(DW-1){1'b0}}, job_busy_i};
                        `DMA_STAT_FULL:      rsp_o.data = {{(DW-1){1'b0}}, ~job_ready_i};
                        default:             rsp_o.data = '0;
                    endcase
                    acc_req_ready_o = rsp_ready_i;
                    rsp_valid_o     = rsp_ready_i;
                end
                default: begin
                    // unknown op is answered with an error
                    rsp_o.error     = 1'b1;
                    acc_req_ready_o = rsp_ready_i;
                    rsp_valid_o     = rsp_ready_i;
                end
            endcase
        end
    end

    //--------------------------------------------------
    // state
    //--------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_q          <= '0;
            dst_q          <= '0;
            src_stride_q   <= '0;
            dst_stride_q   <= '0;
            reps_q         <= '0;
            next_id_q      <= DW'(1);
            completed_id_q <= '0;
        end else begin
            if (req_fire) begin
                case (funct)
                    `DMA_OP_DMSRC: src_q <= acc_req_i.arga;
                    `DMA_OP_DMDST: dst_q <= acc_req_i.arga;
                    `DMA_OP_DMSTR: begin
                        src_stride_q <= acc_req_i.arga;
                        dst_stride_q <= acc_req_i.argb;
                    end
                    `DMA_OP_DMREP: reps_q <= acc_req_i.arga;
                    `DMA_OP_DMCPYI, `DMA_OP_DMCPY: next_id_q <= next_id_q + 1'b1;
                    default: ;
                endcase
            end
            if (job_retire_i) begin
                completed_id_q <= completed_id_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dma_pkg.sv
// --------------------------------------------------
// DMA frontend types
// accelerator bus request/response, operation word,
// queued job and backend burst
// --------------------------------------------------

`default_nettype none

`include "dma_macros.svh"

package dma_pkg;

    // immediate view of the op word
    typedef struct packed {
        logic [`DMA_OP_FUNCT_W-1:0] funct;
        logic [`DMA_OP_CHAN_W-1:0]  chan_sel;
        logic [`DMA_OP_CFG_W-1:0]   cfg;
        logic [`DMA_OP_RSVD_W-1:0]  rsvd;
    } dma_op_fields_t;

    typedef union packed {
        logic [`DMA_DATA_W-1:0] raw;
        dma_op_fields_t         fields;
    } dma_op_u;

    typedef struct packed {
        logic [`DMA_TAG_W-1:0]  tag;
        dma_op_u                op;
        logic [`DMA_DATA_W-1:0] arga;
        logic [`DMA_DATA_W-1:0] argb;
    } acc_req_t;

    typedef struct packed {
        logic [`DMA_TAG_W-1:0]  tag;
        logic [`DMA_DATA_W-1:0] data;
        logic                   error;
    } acc_rsp_t;

    // one 2D job as seen by the midend
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] src;
        logic [`DMA_ADDR_W-1:0] dst;
        logic [`DMA_ADDR_W-1:0] length;
        logic [`DMA_ADDR_W-1:0] src_stride;
        logic [`DMA_ADDR_W-1:0] dst_stride;
        logic [`DMA_ADDR_W-1:0] reps;
        logic                   twod;
    } nd_job_t;

    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] src;
        logic [`DMA_ADDR_W-1:0] dst;
        logic [`DMA_ADDR_W-1:0] length;
    } burst_req_t;

endpackage

`default_nettype wire

//--- rtl/dma_macros.svh
// --------------------------------------------------
// DMA frontend constants
// widths, job queue depth, operation word layout,
// function codes and status selectors
// --------------------------------------------------

`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// data path widths
`define DMA_ADDR_W      32
`define DMA_DATA_W      32
`define DMA_TAG_W       5
`define DMA_FIFO_DEPTH  3

// operation word layout, msb first
`define DMA_OP_FUNCT_W  7
`define DMA_OP_CHAN_W   3
`define DMA_OP_CFG_W    2
`define DMA_OP_RSVD_W   20
`define DMA_CFG_TWOD_BIT 1

// function codes, bits 31:25 of the op word
`define DMA_OP_DMSRC    7'd0
`define DMA_OP_DMDST    7'd1
`define DMA_OP_DMCPYI   7'd2
`define DMA_OP_DMCPY    7'd3
`define DMA_OP_DMSTATI  7'd4
`define DMA_OP_DMSTAT   7'd5
`define DMA_OP_DMSTR    7'd6
`define DMA_OP_DMREP    7'd7

// status selectors
`define DMA_STAT_COMPLETED 2'd0
`define DMA_STAT_NEXT      2'd1
`define DMA_STAT_BUSY      2'd2
`define DMA_STAT_FULL      2'd3

`endif
